// File: decode_input.txt
// insn pc in rs0 rs1 byp0 byp1 rrd exp det(br,jmp,wen,sgn) op sz src0 src1 src2 jpc npc chk(src,jpc)
// in=vld,rv16,byp0,byp1,irdy,ardy,brdy,lrdy,flush,ret,retv exp=drdy,ivld,ill,alu,b,lsu,jvld
00000013 0000 00001111000 10 20 aa0 bb0 00 1001000 0000 0 2 0 0 0 0 00000004 00
123451b7 0100 10001111000 10 20 aa0 bb0 00 1101000 0000 0 2 0 12345000 20 0 00000104 10
00001217 0200 10001111000 10 20 aa0 bb0 00 1101000 0000 0 2 200 1000 20 0 00000204 10
ffd08213 0300 10001111000 10 20 aa0 bb0 00 1101000 0000 0 2 10 fffffffd 20 0 00000304 10
00409313 0400 11001111000 10 20 aa0 bb0 00 1101000 0000 2 2 10 4 20 0 00000402 10
4030d393 0500 10001111000 10 20 aa0 bb0 00 1101000 0000 7 2 10 403 20 0 00000504 10
40208433 0600 10001111000 10 20 aa0 bb0 00 1101000 0000 1 2 10 20 20 0 00000604 10
0020e4b3 0700 10111111000 10 20 aa0 bb0 00 1101000 0000 8 2 aa0 bb0 bb0 0 00000704 10
0080a583 0800 10001111000 10 20 aa0 bb0 00 1100010 0001 0 2 10 8 20 0 00000804 10
0010c603 0900 10001111000 10 20 aa0 bb0 00 1100010 0000 0 0 10 1 20 0 00000904 10
fe209e23 0a00 10011111000 10 20 aa0 bb0 00 1100010 0010 0 1 10 fffffffc bb0 0 00000a04 10
00208863 0b00 10001111000 10 20 aa0 bb0 00 1100100 1000 a 2 0 0 0 0 00000b04 00
00209863 0c00 10001111000 10 20 aa0 bb0 00 1100100 1000 b 2 0 0 0 0 00000c04 00
0020c863 0d00 10001111000 10 20 aa0 bb0 00 1100100 1000 c 2 0 0 0 0 00000d04 00
0020d863 0e00 10001111000 10 20 aa0 bb0 00 1100100 1000 d 2 0 0 0 0 00000e04 00
0020e863 0f00 10001111000 10 20 aa0 bb0 00 1100100 1000 e 2 0 0 0 0 00000f04 00
0020f863 1000 10001101000 10 20 aa0 bb0 00 0000100 1000 f 2 0 0 0 0 00001004 00
008006ef 1100 10001111000 10 20 aa0 bb0 00 1100100 0100 0 2 0 0 0 0 00001104 00
00c08767 1200 10101111000 10 20 aa0 bb0 00 1100101 0100 0 2 0 0 0 aac 00001204 01
00108293 1300 10001111000 10 20 aa0 bb0 00 1101000 0000 0 2 10 1 20 0 00001304 10
002287b3 1304 10001111000 10 20 aa0 bb0 00 0001000 0000 0 2 0 0 0 0 00001308 00
002287b3 1304 10001111011 10 20 aa0 bb0 05 0001000 0000 0 2 0 0 0 0 00001308 00
002287b3 1304 10001111000 10 20 aa0 bb0 00 1101000 0000 0 2 10 20 20 0 00001308 10
00000013 1400 10001111000 10 20 aa0 bb0 00 1101000 0000 0 2 0 0 0 0 00001404 00
00000833 1500 10111111000 10 20 aa0 bb0 00 1101000 0000 0 2 10 20 20 0 00001504 10
002088b3 1600 10000111000 10 20 aa0 bb0 00 0001000 0000 0 2 0 0 0 0 00001604 00
002088b3 1600 10001111100 10 20 aa0 bb0 00 0001000 0000 0 2 0 0 0 0 00001604 00
02208933 1700 10001111000 10 20 aa0 bb0 00 1010000 0000 0 2 0 0 0 0 00001704 00
00000073 1800 10001111000 10 20 aa0 bb0 00 1010000 0000 0 2 0 0 0 0 00001804 00
0000005b 1900 10001111000 10 20 aa0 bb0 00 1010000 0000 0 2 0 0 0 0 00001904 00

// File: project.f
rv_decode_pkg.sv
rv_decode_if.sv
rv_insn_decoder.sv
rv_reg_scoreboard.sv
rv_issue_ctrl.sv
rv_decode_top.sv
tb_clk_gen.sv
tb_rv_decode.sv

// File: rv_decode_if.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded control, decoder to issue controller
interface rv_decode_ctrl_if
    import rv_decode_pkg::*;
();
    src0_sel_e src0_sel;
    src1_sel_e src1_sel;
    xlen_t     imm;
    logic      alu_req;
    logic      b_req;
    logic      lsu_req;
    logic      is_jalr;
    logic      illegal;
    // Unit side fields, read by the top level only
    alu_op_e   alu_op;
    logic      b_is_branch;
    logic      b_is_jump;
    logic      lsu_w_en;
    lsu_size_t lsu_size;
    logic      lsu_signed;

    modport decoder (
        output src0_sel, src1_sel, imm, alu_req, b_req, lsu_req, is_jalr, illegal,
        output alu_op, b_is_branch, b_is_jump, lsu_w_en, lsu_size, lsu_signed
    );

    modport issue (
        input src0_sel, src1_sel, imm, alu_req, b_req, lsu_req, is_jalr, illegal
    );
endinterface

// Register usage and source conflict
interface rv_hazard_if
    import rv_decode_pkg::*;
();
    reg_addr_t rs0_addr;
    reg_addr_t rs1_addr;
    reg_addr_t rd_addr;
    logic      rs0_vld;
    logic      rs1_vld;
    logic      rd_vld;
    logic      issue_fire;
    logic      conflict;

    modport decoder (
        output rs0_addr, rs1_addr, rd_addr, rs0_vld, rs1_vld, rd_vld
    );

    // Addresses needed for the x0 bypass guard
    modport issue (
        input  rs0_addr, rs1_addr, conflict,
        output issue_fire
    );

    modport scoreboard (
        input  rs0_addr, rs1_addr, rd_addr, rs0_vld, rs1_vld, rd_vld, issue_fire,
        output conflict
    );
endinterface

`default_nettype wire

// File: rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

    ////////////////////
    // Widths
    ////////////////////
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Data word, PC and immediate
    typedef logic [XLEN-1:0]       xlen_t;
    // Architectural register index
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    ////////////////////
    // Major opcodes
    ////////////////////
    // Instruction bits 6 to 2, low two bits assumed 2'b11
    typedef enum logic [4:0] {
        OPC_LOAD      = 5'b00000,
        OPC_ARITH_IMM = 5'b00100,
        OPC_AUIPC     = 5'b00101,
        OPC_STORE     = 5'b01000,
        OPC_ARITH     = 5'b01100,
        OPC_LUI       = 5'b01101,
        OPC_BRANCH    = 5'b11000,
        OPC_JALR      = 5'b11001,
        OPC_JAL       = 5'b11011
    } rv_opcode_e;

    // ALU operations, compares shared with the branch unit
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLTS,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_EQ,
        ALU_NE,
        ALU_LTS,
        ALU_GES,
        ALU_LTU,
        ALU_GEU
    } alu_op_e;

    ////////////////////
    // Operand selects
    ////////////////////
    typedef enum logic [1:0] {
        SRC0_RS0,
        SRC0_PC,
        SRC0_ZERO
    } src0_sel_e;

    typedef enum logic {
        SRC1_RS1,
        SRC1_IMM
    } src1_sel_e;

    // Load/store access size, same coding as funct3[1:0]
    typedef logic [1:0] lsu_size_t;
    localparam lsu_size_t LSU_BYTE = 2'd0;
    localparam lsu_size_t LSU_HALF = 2'd1;
    localparam lsu_size_t LSU_WORD = 2'd2;

endpackage

`default_nettype wire

// File: rv_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode_top
    import rv_decode_pkg::*;
#(
    parameter int NUM_REGS = 32
) (
    input  logic      clk_i,
    input  logic      rst_i,
    // Fetch side
    output logic      decode_rdy_o,
    input  xlen_t     insn_i,
    input  xlen_t     insn_pc_i,
    input  logic      insn_vld_i,
    input  logic      insn_is_rv16_i,
    output logic      insn_illegal_o,
    output logic      j_pc_vld_o,
    output xlen_t     j_pc_o,
    output xlen_t     insn_next_pc_o,
    // Retire
    input  logic      retire_vld_i,
    input  logic      retire_rd_addr_vld_i,
    input  reg_addr_t retire_rd_addr_i,
    // Register file
    output reg_addr_t rs0_addr_o,
    input  xlen_t     rs0_data_i,
    output reg_addr_t rs1_addr_o,
    input  xlen_t     rs1_data_i,
    output reg_addr_t rd_addr_o,
    output logic      rs0_vld_o,
    output logic      rs1_vld_o,
    output logic      rd_vld_o,
    // Issue queue and bypass
    input  logic      issue_rdy_i,
    output logic      issue_vld_o,
    input  logic      exec_b_flush_i,
    input  logic      rs0_byp_en_i,
    input  logic      rs1_byp_en_i,
    input  xlen_t     rs0_byp_data_i,
    input  xlen_t     rs1_byp_data_i,
    // Execution operands
    output xlen_t     exec_src0_o,
    output xlen_t     exec_src1_o,
    output xlen_t     exec_src2_o,
    // ALU
    input  logic      alu_rdy_i,
    output logic      alu_req_vld_o,
    output alu_op_e   alu_opc_o,
    // Branch unit
    input  logic      b_rdy_i,
    output logic      b_req_vld_o,
    output logic      b_is_branch_o,
    output logic      b_is_jump_o,
    // LSU
    input  logic      lsu_rdy_i,
    output logic      lsu_req_vld_o,
    output logic      lsu_req_w_en_o,
    output lsu_size_t lsu_req_size_o,
    output logic      lsu_req_signed_o
);

    rv_decode_ctrl_if ctrl ();
    rv_hazard_if      hz ();

    // Sequential PC, compressed or full width
    assign insn_next_pc_o = insn_pc_i + (insn_is_rv16_i ? xlen_t'(2) : xlen_t'(4));

    rv_insn_decoder u_decoder (
        .insn_i (insn_i),
        .ctrl   (ctrl.decoder),
        .hz     (hz.decoder)
    );

    rv_reg_scoreboard #(
        .NUM_REGS (NUM_REGS)
    ) u_scoreboard (
        .clk_i                (clk_i),
        .rst_i                (rst_i),
        .hz                   (hz.scoreboard),
        .retire_vld_i         (retire_vld_i),
        .retire_rd_addr_vld_i (retire_rd_addr_vld_i),
        .retire_rd_addr_i     (retire_rd_addr_i)
    );

    rv_issue_ctrl u_issue (
        .ctrl           (ctrl.issue),
        .hz             (hz.issue),
        .insn_vld_i     (insn_vld_i),
        .insn_pc_i      (insn_pc_i),
        .rs0_data_i     (rs0_data_i),
        .rs1_data_i     (rs1_data_i),
        .rs0_byp_en_i   (rs0_byp_en_i),
        .rs1_byp_en_i   (rs1_byp_en_i),
        .rs0_byp_data_i (rs0_byp_data_i),
        .rs1_byp_data_i (rs1_byp_data_i),
        .alu_rdy_i      (alu_rdy_i),
        .b_rdy_i        (b_rdy_i),
        .lsu_rdy_i      (lsu_rdy_i),
        .issue_rdy_i    (issue_rdy_i),
        .exec_b_flush_i (exec_b_flush_i),
        .exec_src0_o    (exec_src0_o),
        .exec_src1_o    (exec_src1_o),
        .exec_src2_o    (exec_src2_o),
        .j_pc_o         (j_pc_o),
        .j_pc_vld_o     (j_pc_vld_o),
        .issue_vld_o    (issue_vld_o),
        .decode_rdy_o   (decode_rdy_o)
    );

    ////////////////////
    // Plain port fan-out
    ////////////////////
    assign rs0_addr_o       = hz.rs0_addr;
    assign rs1_addr_o       = hz.rs1_addr;
    assign rd_addr_o        = hz.rd_addr;
    assign rs0_vld_o        = hz.rs0_vld;
    assign rs1_vld_o        = hz.rs1_vld;
    assign rd_vld_o         = hz.rd_vld;
    assign insn_illegal_o   = ctrl.illegal;
    assign alu_req_vld_o    = ctrl.alu_req;
    assign alu_opc_o        = ctrl.alu_op;
    assign b_req_vld_o      = ctrl.b_req;
    assign b_is_branch_o    = ctrl.b_is_branch;
    assign b_is_jump_o      = ctrl.b_is_jump;
    assign lsu_req_vld_o    = ctrl.lsu_req;
    assign lsu_req_w_en_o   = ctrl.lsu_w_en;
    assign lsu_req_size_o   = ctrl.lsu_size;
    assign lsu_req_signed_o = ctrl.lsu_signed;

endmodule

`default_nettype wire

// File: rv_insn_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_insn_decoder
    import rv_decode_pkg::*;
(
    input  xlen_t             insn_i,
    rv_decode_ctrl_if.decoder ctrl,
    rv_hazard_if.decoder      hz
);

    // Immediate formats kept by this core
    typedef enum logic [1:0] {
        IMM_I,
        IMM_S,
        IMM_U
    } imm_sel_e;

    rv_opcode_e opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    imm_sel_e   imm_sel;
    logic       illegal;
    logic       alu_req;
    logic       b_req;
    logic       lsu_req;
    logic       is_jalr;
    logic       rs0_vld;
    logic       rs1_vld;
    logic       rd_vld;

    ////////////////////
    // Fields
    ////////////////////
    assign opcode      = rv_opcode_e'(insn_i[6:2]);
    assign funct3      = insn_i[14:12];
    assign funct7      = insn_i[31:25];
    assign hz.rs0_addr = insn_i[19:15];
    assign hz.rs1_addr = insn_i[24:20];
    assign hz.rd_addr  = insn_i[11:7];

    ////////////////////
    // Immediate
    ////////////////////
    always_comb begin
        case (imm_sel)
            IMM_S:   ctrl.imm = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};
            IMM_U:   ctrl.imm = {insn_i[31:12], 12'b0};
            default: ctrl.imm = {{20{insn_i[31]}}, insn_i[31:20]};
        endcase
    end

    ////////////////////
    // Opcode decode
    ////////////////////
    always_comb begin
        // Defaults, register-register ALU shape
        ctrl.src0_sel    = SRC0_RS0;
        ctrl.src1_sel    = SRC1_RS1;
        ctrl.alu_op      = ALU_ADD;
        ctrl.b_is_branch = 1'b0;
        ctrl.b_is_jump   = 1'b0;
        ctrl.lsu_w_en    = 1'b0;
        ctrl.lsu_size    = LSU_WORD;
        ctrl.lsu_signed  = 1'b0;
        imm_sel          = IMM_I;
        illegal          = 1'b0;
        alu_req          = 1'b0;
        b_req            = 1'b0;
        lsu_req          = 1'b0;
        is_jalr          = 1'b0;
        rs0_vld          = 1'b0;
        rs1_vld          = 1'b0;
        rd_vld           = 1'b1;
        case (opcode)
            OPC_LUI: begin
                // 0 + U immediate
                ctrl.src0_sel = SRC0_ZERO;
                ctrl.src1_sel = SRC1_IMM;
                imm_sel       = IMM_U;
                alu_req       = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.src0_sel = SRC0_PC;
                ctrl.src1_sel = SRC1_IMM;
                imm_sel       = IMM_U;
                alu_req       = 1'b1;
            end
            OPC_ARITH_IMM: begin
                ctrl.src1_sel = SRC1_IMM;
                rs0_vld       = 1'b1;
                alu_req       = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = ALU_ADD;
                    3'b010:  ctrl.alu_op = ALU_SLTS;
                    3'b011:  ctrl.alu_op = ALU_SLTU;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    3'b001: begin
                        ctrl.alu_op = ALU_SLL;
                        illegal     = (funct7 != 7'b0000000);
                    end
                    default: begin
                        // Shift right, funct7 picks logical or arithmetic
                        ctrl.alu_op = (funct7[5]) ? ALU_SRA : ALU_SRL;
                        illegal     = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                    end
                endcase
            end
            OPC_ARITH: begin
                rs0_vld = 1'b1;
                rs1_vld = 1'b1;
                alu_req = 1'b1;
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  ctrl.alu_op = ALU_ADD;
                        3'b001:  ctrl.alu_op = ALU_SLL;
                        3'b010:  ctrl.alu_op = ALU_SLTS;
                        3'b011:  ctrl.alu_op = ALU_SLTU;
                        3'b100:  ctrl.alu_op = ALU_XOR;
                        3'b101:  ctrl.alu_op = ALU_SRL;
                        3'b110:  ctrl.alu_op = ALU_OR;
                        default: ctrl.alu_op = ALU_AND;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    ctrl.alu_op = ALU_SUB;
                end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
                    ctrl.alu_op = ALU_SRA;
                end else begin
                    // MUL/DIV (funct7 = 1) not supported here
                    illegal = 1'b1;
                end
            end
            OPC_JAL: begin
                b_req          = 1'b1;
                ctrl.b_is_jump = 1'b1;
            end
            OPC_JALR: begin
                rs0_vld        = 1'b1;
                b_req          = 1'b1;
                ctrl.b_is_jump = 1'b1;
                is_jalr        = 1'b1;
                illegal        = (funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                rs0_vld          = 1'b1;
                rs1_vld          = 1'b1;
                rd_vld           = 1'b0;
                b_req            = 1'b1;
                ctrl.b_is_branch = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = ALU_EQ;
                    3'b001:  ctrl.alu_op = ALU_NE;
                    3'b100:  ctrl.alu_op = ALU_LTS;
                    3'b101:  ctrl.alu_op = ALU_GES;
                    3'b110:  ctrl.alu_op = ALU_LTU;
                    3'b111:  ctrl.alu_op = ALU_GEU;
                    default: illegal     = 1'b1;
                endcase
            end
            OPC_LOAD: begin
                ctrl.src1_sel   = SRC1_IMM;
                rs0_vld         = 1'b1;
                lsu_req         = 1'b1;
                ctrl.lsu_signed = ~funct3[2];
                case (funct3[1:0])
                    LSU_BYTE: ctrl.lsu_size = LSU_BYTE;
                    LSU_HALF: ctrl.lsu_size = LSU_HALF;
                    // No unsigned word load on RV32
                    LSU_WORD: illegal       = funct3[2];
                    default:  illegal       = 1'b1;
                endcase
            end
            OPC_STORE: begin
                ctrl.src1_sel = SRC1_IMM;
                imm_sel       = IMM_S;
                rs0_vld       = 1'b1;
                rs1_vld       = 1'b1;
                rd_vld        = 1'b0;
                lsu_req       = 1'b1;
                ctrl.lsu_w_en = 1'b1;
                ctrl.lsu_size = funct3[1:0];
                illegal       = funct3[2] || (funct3[1:0] == 2'b11);
            end
            // SYSTEM, FENCE and anything unknown
            default: illegal = 1'b1;
        endcase
    end

    ////////////////////
    // Illegal squash
    ////////////////////
    // Nothing requested, read or written for an illegal word
    assign ctrl.illegal = illegal;
    assign ctrl.alu_req = alu_req & ~illegal;
    assign ctrl.b_req   = b_req & ~illegal;
    assign ctrl.lsu_req = lsu_req & ~illegal;
    assign ctrl.is_jalr = is_jalr & ~illegal;
    assign hz.rs0_vld   = rs0_vld & ~illegal;
    assign hz.rs1_vld   = rs1_vld & ~illegal;
    assign hz.rd_vld    = rd_vld & ~illegal;

endmodule

`default_nettype wire

// File: rv_issue_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rv_issue_ctrl
    import rv_decode_pkg::*;
(
    rv_decode_ctrl_if.issue ctrl,
    rv_hazard_if.issue      hz,
    input  logic            insn_vld_i,
    input  xlen_t           insn_pc_i,
    input  xlen_t           rs0_data_i,
    input  xlen_t           rs1_data_i,
    input  logic            rs0_byp_en_i,
    input  logic            rs1_byp_en_i,
    input  xlen_t           rs0_byp_data_i,
    input  xlen_t           rs1_byp_data_i,
    input  logic            alu_rdy_i,
    input  logic            b_rdy_i,
    input  logic            lsu_rdy_i,
    input  logic            issue_rdy_i,
    input  logic            exec_b_flush_i,
    output xlen_t           exec_src0_o,
    output xlen_t           exec_src1_o,
    output xlen_t           exec_src2_o,
    output xlen_t           j_pc_o,
    output logic            j_pc_vld_o,
    output logic            issue_vld_o,
    output logic            decode_rdy_o
);

    xlen_t rs0_val;
    xlen_t rs1_val;
    logic  unit_grant;

    ////////////////////
    // WB bypass
    ////////////////////
    // x0 always reads the register file value
    assign rs0_val = (rs0_byp_en_i && hz.rs0_addr != '0) ? rs0_byp_data_i : rs0_data_i;
    assign rs1_val = (rs1_byp_en_i && hz.rs1_addr != '0) ? rs1_byp_data_i : rs1_data_i;

    // Operand 0
    always_comb begin
        case (ctrl.src0_sel)
            SRC0_RS0: exec_src0_o = rs0_val;
            SRC0_PC:  exec_src0_o = insn_pc_i;
            default:  exec_src0_o = '0;
        endcase
    end

    // Operand 1, register or immediate
    assign exec_src1_o = (ctrl.src1_sel == SRC1_IMM) ? ctrl.imm : rs1_val;
    // Store data
    assign exec_src2_o = rs1_val;

    // JALR target back to fetch
    assign j_pc_o     = rs0_val + ctrl.imm;
    assign j_pc_vld_o = ctrl.is_jalr & insn_vld_i & issue_rdy_i;

    ////////////////////
    // Issue decision
    ////////////////////
    assign unit_grant = (ctrl.alu_req & alu_rdy_i)
                      | (ctrl.b_req & b_rdy_i)
                      | (ctrl.lsu_req & lsu_rdy_i);

    assign issue_vld_o = insn_vld_i & unit_grant & ~hz.conflict & issue_rdy_i
                       & ~exec_b_flush_i & ~ctrl.illegal;
    assign hz.issue_fire = issue_vld_o;

    // Illegal word dropped so fetch moves on
    assign decode_rdy_o = ~insn_vld_i | issue_vld_o | ctrl.illegal;

endmodule

`default_nettype wire

// File: rv_reg_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module rv_reg_scoreboard
    import rv_decode_pkg::*;
#(
    parameter int NUM_REGS = 32
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    rv_hazard_if.scoreboard        hz,
    input  logic                   retire_vld_i,
    input  logic                   retire_rd_addr_vld_i,
    input  reg_addr_t              retire_rd_addr_i
);

    logic [NUM_REGS-1:0] pend_q;
    logic [NUM_REGS-1:0] pend_d;
    logic                set_en;
    logic                clr_en;
    logic                rs0_busy;
    logic                rs1_busy;

    // Mark rd on issue, x0 and out of range registers never tracked
    assign set_en = hz.issue_fire && hz.rd_vld && (hz.rd_addr != '0)
                    && (int'(hz.rd_addr) < NUM_REGS);
    assign clr_en = retire_vld_i && retire_rd_addr_vld_i
                    && (int'(retire_rd_addr_i) < NUM_REGS);

    always_comb begin
        pend_d = pend_q;
        if (clr_en) begin
            pend_d[retire_rd_addr_i] = 1'b0;
        end
        // Set applied last so it wins over a same-register clear
        if (set_en) begin
            pend_d[hz.rd_addr] = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pend_q <= '0;
        end else begin
            pend_q <= pend_d;
        end
    end

    // Source reads against pending writes
    assign rs0_busy    = hz.rs0_vld && (int'(hz.rs0_addr) < NUM_REGS) && pend_q[hz.rs0_addr];
    assign rs1_busy    = hz.rs1_vld && (int'(hz.rs1_addr) < NUM_REGS) && pend_q[hz.rs1_addr];
    assign hz.conflict = rs0_busy | rs1_busy;

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int HALF_PERIOD_NS = 2,
    parameter int RST_CYCLES     = 5
) (
    output logic clk_o,
    output logic rst_o
);

    // 4 ns clock
    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    // Reset held over the first rising edges, released off the edge
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

// File: tb_rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_decode
    import rv_decode_pkg::*;
();

    localparam int MAX_VEC      = 64;
    localparam int RST_CYCLES   = 5;
    localparam int SLACK_CYCLES = 20;

    logic      clk;
    logic      rst;
    // DUT inputs
    xlen_t     insn;
    xlen_t     insn_pc;
    logic      insn_vld;
    logic      insn_is_rv16;
    logic      retire_vld;
    logic      retire_rd_addr_vld;
    reg_addr_t retire_rd_addr;
    xlen_t     rs0_data;
    xlen_t     rs1_data;
    logic      issue_rdy;
    logic      exec_b_flush;
    logic      rs0_byp_en;
    logic      rs1_byp_en;
    xlen_t     rs0_byp_data;
    xlen_t     rs1_byp_data;
    logic      alu_rdy;
    logic      b_rdy;
    logic      lsu_rdy;
    // DUT outputs
    logic      decode_rdy;
    logic      insn_illegal;
    logic      j_pc_vld;
    xlen_t     j_pc;
    xlen_t     insn_next_pc;
    reg_addr_t rs0_addr;
    reg_addr_t rs1_addr;
    reg_addr_t rd_addr;
    logic      rs0_vld;
    logic      rs1_vld;
    logic      rd_vld;
    logic      issue_vld;
    xlen_t     exec_src0;
    xlen_t     exec_src1;
    xlen_t     exec_src2;
    logic      alu_req_vld;
    alu_op_e   alu_opc;
    logic      b_req_vld;
    logic      b_is_branch;
    logic      b_is_jump;
    logic      lsu_req_vld;
    logic      lsu_req_w_en;
    lsu_size_t lsu_req_size;
    logic      lsu_req_signed;

    ////////////////////
    // Vector store
    ////////////////////
    xlen_t       v_insn      [MAX_VEC];
    xlen_t       v_pc        [MAX_VEC];
    logic [10:0] v_in_flags  [MAX_VEC];
    xlen_t       v_rs0       [MAX_VEC];
    xlen_t       v_rs1       [MAX_VEC];
    xlen_t       v_byp0      [MAX_VEC];
    xlen_t       v_byp1      [MAX_VEC];
    reg_addr_t   v_ret_rd    [MAX_VEC];
    logic [6:0]  v_exp_flags [MAX_VEC];
    logic [3:0]  v_detail    [MAX_VEC];
    logic [3:0]  v_op        [MAX_VEC];
    lsu_size_t   v_size      [MAX_VEC];
    xlen_t       v_src0      [MAX_VEC];
    xlen_t       v_src1      [MAX_VEC];
    xlen_t       v_src2      [MAX_VEC];
    xlen_t       v_jpc       [MAX_VEC];
    xlen_t       v_npc       [MAX_VEC];
    logic [1:0]  v_chk       [MAX_VEC];

    int num_vec     = 0;
    int cur_vec     = 0;
    int cycle_cnt   = 0;
    int cycle_limit = 0;

    tb_clk_gen #(
        .HALF_PERIOD_NS (2),
        .RST_CYCLES     (RST_CYCLES)
    ) u_clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    rv_decode_top #(
        .NUM_REGS (32)
    ) dut (
        .clk_i                (clk),
        .rst_i                (rst),
        .decode_rdy_o         (decode_rdy),
        .insn_i               (insn),
        .insn_pc_i            (insn_pc),
        .insn_vld_i           (insn_vld),
        .insn_is_rv16_i       (insn_is_rv16),
        .insn_illegal_o       (insn_illegal),
        .j_pc_vld_o           (j_pc_vld),
        .j_pc_o               (j_pc),
        .insn_next_pc_o       (insn_next_pc),
        .retire_vld_i         (retire_vld),
        .retire_rd_addr_vld_i (retire_rd_addr_vld),
        .retire_rd_addr_i     (retire_rd_addr),
        .rs0_addr_o           (rs0_addr),
        .rs0_data_i           (rs0_data),
        .rs1_addr_o           (rs1_addr),
        .rs1_data_i           (rs1_data),
        .rd_addr_o            (rd_addr),
        .rs0_vld_o            (rs0_vld),
        .rs1_vld_o            (rs1_vld),
        .rd_vld_o             (rd_vld),
        .issue_rdy_i          (issue_rdy),
        .issue_vld_o          (issue_vld),
        .exec_b_flush_i       (exec_b_flush),
        .rs0_byp_en_i         (rs0_byp_en),
        .rs1_byp_en_i         (rs1_byp_en),
        .rs0_byp_data_i       (rs0_byp_data),
        .rs1_byp_data_i       (rs1_byp_data),
        .exec_src0_o          (exec_src0),
        .exec_src1_o          (exec_src1),
        .exec_src2_o          (exec_src2),
        .alu_rdy_i            (alu_rdy),
        .alu_req_vld_o        (alu_req_vld),
        .alu_opc_o            (alu_opc),
        .b_rdy_i              (b_rdy),
        .b_req_vld_o          (b_req_vld),
        .b_is_branch_o        (b_is_branch),
        .b_is_jump_o          (b_is_jump),
        .lsu_rdy_i            (lsu_rdy),
        .lsu_req_vld_o        (lsu_req_vld),
        .lsu_req_w_en_o       (lsu_req_w_en),
        .lsu_req_size_o       (lsu_req_size),
        .lsu_req_signed_o     (lsu_req_signed)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "Run aborted");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            abort_run($sformatf("MISMATCH at %0d ns, vector %0d: %s expected %h, got %h",
                                $time, cur_vec, name, exp, got));
        end
    endtask

    // Registers an RV32I format reads and writes, as {rs0, rs1, rd}
    function automatic logic [2:0] regs_used(input xlen_t word);
        case (word[6:0])
            7'b0110111, 7'b0010111, 7'b1101111: regs_used = 3'b001;
            7'b1100111, 7'b0010011, 7'b0000011: regs_used = 3'b101;
            7'b0110011:                         regs_used = 3'b111;
            7'b1100011, 7'b0100011:             regs_used = 3'b110;
            default:                            regs_used = 3'b000;
        endcase
    endfunction

    // Run limit from the vector count
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0) begin
            assert (cycle_cnt < cycle_limit) else begin
                abort_run($sformatf("Timeout: run still going after %0d cycles", cycle_limit));
            end
        end
    end

    ////////////////////
    // Vector file
    ////////////////////
    task automatic load_vectors();
        int    fd;
        int    n;
        string line;
        fd = $fopen("decode_input.txt", "r");
        assert (fd != 0) else begin
            abort_run("Could not open the vector file decode_input.txt");
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%h %h %b %h %h %h %h %h %b %b %h %h %h %h %h %h %h %b",
                        v_insn[num_vec], v_pc[num_vec], v_in_flags[num_vec],
                        v_rs0[num_vec], v_rs1[num_vec], v_byp0[num_vec], v_byp1[num_vec],
                        v_ret_rd[num_vec], v_exp_flags[num_vec], v_detail[num_vec],
                        v_op[num_vec], v_size[num_vec], v_src0[num_vec], v_src1[num_vec],
                        v_src2[num_vec], v_jpc[num_vec], v_npc[num_vec], v_chk[num_vec]);
            if (n == 18) begin
                assert (num_vec < MAX_VEC) else begin
                    abort_run("Vector file holds more lines than the testbench can store");
                end
                num_vec++;
            end else if (line.len() > 1 && line.substr(0, 1) != "//") begin
                abort_run($sformatf("Malformed vector line: %s", line));
            end
        end
        $fclose(fd);
        assert (num_vec > 0) else begin
            abort_run("Vector file holds no vectors");
        end
    endtask

    task automatic init_inputs();
        insn               = '0;
        insn_pc            = '0;
        insn_vld           = 1'b0;
        insn_is_rv16       = 1'b0;
        retire_vld         = 1'b0;
        retire_rd_addr_vld = 1'b0;
        retire_rd_addr     = '0;
        rs0_data           = '0;
        rs1_data           = '0;
        issue_rdy          = 1'b0;
        exec_b_flush       = 1'b0;
        rs0_byp_en         = 1'b0;
        rs1_byp_en         = 1'b0;
        rs0_byp_data       = '0;
        rs1_byp_data       = '0;
        alu_rdy            = 1'b0;
        b_rdy              = 1'b0;
        lsu_rdy            = 1'b0;
    endtask

    task automatic apply_vector(input int i);
        logic [10:0] f;
        f                  = v_in_flags[i];
        insn               = v_insn[i];
        insn_pc            = v_pc[i];
        rs0_data           = v_rs0[i];
        rs1_data           = v_rs1[i];
        rs0_byp_data       = v_byp0[i];
        rs1_byp_data       = v_byp1[i];
        retire_rd_addr     = v_ret_rd[i];
        // Flag column, left to right
        insn_vld           = f[10];
        insn_is_rv16       = f[9];
        rs0_byp_en         = f[8];
        rs1_byp_en         = f[7];
        issue_rdy          = f[6];
        alu_rdy            = f[5];
        b_rdy              = f[4];
        lsu_rdy            = f[3];
        exec_b_flush       = f[2];
        retire_vld         = f[1];
        retire_rd_addr_vld = f[0];
    endtask

    task automatic check_vector(input int i);
        logic [6:0] ef;
        logic [3:0] det;
        alu_op_e    exp_op;
        xlen_t      word;
        logic [2:0] use_exp;
        ef      = v_exp_flags[i];
        det     = v_detail[i];
        exp_op  = alu_op_e'(v_op[i]);
        word    = v_insn[i];
        use_exp = regs_used(word);
        // Handshake and requests, every cycle
        check_val("decode_rdy_o", decode_rdy, ef[6]);
        check_val("issue_vld_o", issue_vld, ef[5]);
        check_val("insn_illegal_o", insn_illegal, ef[4]);
        check_val("alu_req_vld_o", alu_req_vld, ef[3]);
        check_val("b_req_vld_o", b_req_vld, ef[2]);
        check_val("lsu_req_vld_o", lsu_req_vld, ef[1]);
        check_val("j_pc_vld_o", j_pc_vld, ef[0]);
        check_val("insn_next_pc_o", insn_next_pc, v_npc[i]);
        // Register file addresses at the RV32I field positions
        check_val("rs0_addr_o", rs0_addr, word[19:15]);
        check_val("rs1_addr_o", rs1_addr, word[24:20]);
        check_val("rd_addr_o", rd_addr, word[11:7]);
        // Branch unit flags and register use of a legal word
        if (!ef[4]) begin
            check_val("b_is_branch_o", b_is_branch, det[3]);
            check_val("b_is_jump_o", b_is_jump, det[2]);
            check_val("rs0_vld_o", rs0_vld, use_exp[2]);
            check_val("rs1_vld_o", rs1_vld, use_exp[1]);
            check_val("rd_vld_o", rd_vld, use_exp[0]);
        end
        // Opcode only for ALU work and compares
        if (ef[3] || det[3]) begin
            check_val("alu_opc_o", alu_opc, exp_op);
        end
        if (ef[1]) begin
            check_val("lsu_req_w_en_o", lsu_req_w_en, det[1]);
            check_val("lsu_req_size_o", lsu_req_size, v_size[i]);
            check_val("lsu_req_signed_o", lsu_req_signed, det[0]);
        end
        if (v_chk[i][1]) begin
            check_val("exec_src0_o", exec_src0, v_src0[i]);
            check_val("exec_src1_o", exec_src1, v_src1[i]);
            check_val("exec_src2_o", exec_src2, v_src2[i]);
        end
        if (v_chk[i][0]) begin
            check_val("j_pc_o", j_pc, v_jpc[i]);
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        init_inputs();
        load_vectors();
        cycle_limit = num_vec + RST_CYCLES + SLACK_CYCLES;
        wait (rst == 1'b0);
        // Drive 1 ns after the edge, sample 1 ns before the next
        for (int i = 0; i < num_vec; i++) begin
            @(posedge clk);
            #1;
            cur_vec = i;
            apply_vector(i);
            #2;
            check_vector(i);
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire
